// File: rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } rv32i_opcode;

    // format layouts, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_format;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_format;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_format;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_format;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_format;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_format;

    // one word, six views
    typedef union packed {
        r_format r;
        i_format i;
        s_format s;
        b_format b;
        u_format u;
        j_format j;
    } rv32i_instr;

endpackage

// File: issue_pkg.sv
package issue_pkg;

    // operation class handed to the reservation stations
    typedef enum logic [2:0] {
        ARITH,
        LUI,
        AUIPC,
        BRANCH,
        JAL,
        JALR,
        LD,
        ST
    } op_class;

    localparam int REG_W = 5;   // register number
    localparam int F3_W  = 3;   // funct3

    // packed control word, msb to lsb:
    //   src1_reg  REG_W
    //   src2_reg  REG_W
    //   rd        REG_W
    //   funct3    F3_W
    //   funct7    1      alternate bit only
    //   op        3
    //   src2_data 32
    //   src2_valid 1
    //   cw_pc     32
    localparam int CW_W = 3 * REG_W + F3_W + 1 + $bits(op_class) + 32 + 1 + 32;

endpackage

// File: pc_counter.sv
`timescale 1ns/1ps

module pc_counter #(
    parameter rv32i_pkg::rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ld_pc,
    input  logic                 redirect,
    input  rv32i_pkg::rv32i_word redirect_pc,
    output rv32i_pkg::rv32i_word pc
);

    // redirect wins over the sequential step
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (ld_pc) begin
            pc <= pc + 32'd4;   // next word, no compressed support
        end
    end

endmodule

// File: fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic instr_mem_resp,
    input  logic iq_accept,
    input  logic redirect,
    output logic instr_read,
    output logic ld_instr,
    output logic ld_iq,
    output logic ld_pc
);

    typedef enum logic [1:0] {
        RESET,
        FETCH,
        CREATE,
        STALL
    } state_t;

    state_t state, next_state;
    logic   discard;   // response of a redirected request still to come

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RESET;
            discard <= 1'b0;
        end else begin
            state <= next_state;
            if (redirect) begin
                // request in flight with no answer yet, drop its answer later
                discard <= (state == FETCH) && !instr_mem_resp;
            end else if (instr_mem_resp) begin
                discard <= 1'b0;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET: next_state = FETCH;
            FETCH: begin
                if (redirect) begin
                    next_state = FETCH;
                end else if (instr_mem_resp && !discard) begin
                    next_state = CREATE;
                end
            end
            CREATE: begin
                if (redirect || iq_accept) begin
                    next_state = FETCH;
                end else begin
                    next_state = STALL;
                end
            end
            STALL: begin
                if (redirect || iq_accept) begin
                    next_state = FETCH;
                end
            end
            default: next_state = RESET;
        endcase
    end

    // request held until the response arrives
    assign instr_read = (state == FETCH);
    assign ld_instr   = instr_mem_resp && (state == FETCH) && !discard;
    assign ld_iq      = (state == CREATE) || (state == STALL);
    assign ld_pc      = ld_iq && iq_accept;   // step only once the entry is taken

endmodule

// File: instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             ld_instr,
    input  rv32i_pkg::rv32i_word             instr_rdata,
    input  rv32i_pkg::rv32i_word             pc,
    output logic [issue_pkg::REG_W-1:0]      src1_reg,
    output logic [issue_pkg::REG_W-1:0]      src2_reg,
    output logic [issue_pkg::REG_W-1:0]      rd,
    output logic [issue_pkg::F3_W-1:0]       funct3,
    output logic                             funct7,
    output issue_pkg::op_class               op,
    output rv32i_pkg::rv32i_word             src2_data,
    output logic                             src2_valid,
    output rv32i_pkg::rv32i_word             cw_pc
);

    import rv32i_pkg::*;
    import issue_pkg::*;

    rv32i_instr  ir;
    rv32i_word   ir_pc;
    rv32i_opcode opcode;
    rv32i_word   i_imm, s_imm, b_imm, u_imm, j_imm;

    // instruction register and the pc it was fetched from
    always_ff @(posedge clk) begin
        if (rst) begin
            ir    <= '0;
            ir_pc <= '0;
        end else if (ld_instr) begin
            ir    <= instr_rdata;
            ir_pc <= pc;
        end
    end

    assign opcode   = rv32i_opcode'(ir.r.opcode);
    assign src1_reg = ir.r.rs1;
    assign src2_reg = ir.r.rs2;
    assign rd       = ir.r.rd;
    assign funct3   = ir.r.funct3;
    assign funct7   = ir.r.funct7[5];   // sub / sra select
    assign cw_pc    = ir_pc;

    assign i_imm = {{20{ir.i.imm[11]}}, ir.i.imm};
    assign s_imm = {{20{ir.s.imm_11_5[6]}}, ir.s.imm_11_5, ir.s.imm_4_0};
    assign b_imm = {{19{ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11,
                    ir.b.imm_10_5, ir.b.imm_4_1, 1'b0};
    assign u_imm = {ir.u.imm_31_12, 12'h000};
    assign j_imm = {{11{ir.j.imm_20}}, ir.j.imm_20, ir.j.imm_19_12,
                    ir.j.imm_11, ir.j.imm_10_1, 1'b0};

    always_comb begin
        op         = ARITH;
        src2_data  = '0;
        src2_valid = 1'b0;
        case (opcode)
            op_lui: begin
                op         = LUI;
                src2_data  = u_imm;
                src2_valid = 1'b1;
            end
            op_auipc: begin
                op         = AUIPC;
                src2_data  = u_imm;
                src2_valid = 1'b1;
            end
            op_jal: begin
                op         = JAL;
                src2_data  = j_imm;
                src2_valid = 1'b1;
            end
            op_jalr: begin
                op         = JALR;
                src2_data  = i_imm;
                src2_valid = 1'b1;
            end
            op_br: begin
                op         = BRANCH;
                src2_data  = b_imm;
                src2_valid = 1'b1;
            end
            op_load: begin
                op         = LD;
                src2_data  = i_imm;
                src2_valid = 1'b1;
            end
            op_store: begin
                op         = ST;
                src2_data  = s_imm;
                src2_valid = 1'b1;
            end
            op_imm, op_csr: begin   // csr issues as arith
                src2_data  = i_imm;
                src2_valid = 1'b1;
            end
            default: ;   // reg and unknown opcodes, no immediate
        endcase
    end

endmodule

// File: instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(
    parameter int IQ_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        ld_iq,
    input  logic [issue_pkg::REG_W-1:0] dec_src1_reg,
    input  logic [issue_pkg::REG_W-1:0] dec_src2_reg,
    input  logic [issue_pkg::REG_W-1:0] dec_rd,
    input  logic [issue_pkg::F3_W-1:0]  dec_funct3,
    input  logic                        dec_funct7,
    input  issue_pkg::op_class          dec_op,
    input  rv32i_pkg::rv32i_word        dec_src2_data,
    input  logic                        dec_src2_valid,
    input  rv32i_pkg::rv32i_word        dec_cw_pc,
    input  logic                        iq_deq,
    output logic                        iq_accept,
    output logic                        iq_valid,
    output logic [issue_pkg::REG_W-1:0] src1_reg,
    output logic [issue_pkg::REG_W-1:0] src2_reg,
    output logic [issue_pkg::REG_W-1:0] rd,
    output logic [issue_pkg::F3_W-1:0]  funct3,
    output logic                        funct7,
    output issue_pkg::op_class          op,
    output rv32i_pkg::rv32i_word        src2_data,
    output logic                        src2_valid,
    output rv32i_pkg::rv32i_word        cw_pc
);

    import issue_pkg::*;

    localparam int PTR_W = $clog2(IQ_DEPTH);

    logic [CW_W-1:0]           entries [IQ_DEPTH];
    logic [CW_W-1:0]           wr_word;
    logic [PTR_W-1:0]          rd_ptr, wr_ptr;
    logic [PTR_W:0]            count;
    logic                      full, empty, pop;
    logic [$bits(op_class)-1:0] head_op;

    assign full      = (count == IQ_DEPTH[PTR_W:0]);
    assign empty     = (count == '0);
    assign iq_accept = ld_iq && !full;
    assign pop       = iq_deq && !empty;   // pop on empty is ignored
    assign iq_valid  = !empty;

    assign wr_word = {dec_src1_reg, dec_src2_reg, dec_rd, dec_funct3, dec_funct7,
                      dec_op, dec_src2_data, dec_src2_valid, dec_cw_pc};

    always_ff @(posedge clk) begin
        if (iq_accept) begin
            entries[wr_ptr] <= wr_word;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (iq_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (iq_accept ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
        end
    end

    assign {src1_reg, src2_reg, rd, funct3, funct7, head_op,
            src2_data, src2_valid, cw_pc} = entries[rd_ptr];
    assign op = op_class'(head_op);

endmodule

// File: fetch_decode_top.sv
`timescale 1ns/1ps

module fetch_decode_top #(
    parameter rv32i_pkg::rv32i_word RESET_PC = 32'h0000_0000,
    parameter int                   IQ_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_mem_resp,
    input  rv32i_pkg::rv32i_word        instr_rdata,
    output logic                        instr_read,
    output rv32i_pkg::rv32i_word        instr_mem_address,
    input  logic                        redirect,
    input  rv32i_pkg::rv32i_word        redirect_pc,
    input  logic                        iq_deq,
    output logic                        iq_valid,
    output logic [issue_pkg::REG_W-1:0] src1_reg,
    output logic [issue_pkg::REG_W-1:0] src2_reg,
    output logic [issue_pkg::REG_W-1:0] rd,
    output logic [issue_pkg::F3_W-1:0]  funct3,
    output logic                        funct7,
    output issue_pkg::op_class          op,
    output rv32i_pkg::rv32i_word        src2_data,
    output logic                        src2_valid,
    output rv32i_pkg::rv32i_word        cw_pc
);

    import rv32i_pkg::*;
    import issue_pkg::*;

    logic ld_instr, ld_iq, ld_pc, iq_accept;

    // decoder to queue
    logic [REG_W-1:0] dec_src1_reg, dec_src2_reg, dec_rd;
    logic [F3_W-1:0]  dec_funct3;
    logic             dec_funct7, dec_src2_valid;
    op_class          dec_op;
    rv32i_word        dec_src2_data, dec_cw_pc;

    pc_counter #(
        .RESET_PC (RESET_PC)
    ) pc_counter_inst (
        .clk         (clk),
        .rst         (rst),
        .ld_pc       (ld_pc),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (instr_mem_address)   // the pc is the fetch address
    );

    fetch_ctrl fetch_ctrl_inst (
        .clk            (clk),
        .rst            (rst),
        .instr_mem_resp (instr_mem_resp),
        .iq_accept      (iq_accept),
        .redirect       (redirect),
        .instr_read     (instr_read),
        .ld_instr       (ld_instr),
        .ld_iq          (ld_iq),
        .ld_pc          (ld_pc)
    );

    instr_decoder instr_decoder_inst (
        .clk         (clk),
        .rst         (rst),
        .ld_instr    (ld_instr),
        .instr_rdata (instr_rdata),
        .pc          (instr_mem_address),
        .src1_reg    (dec_src1_reg),
        .src2_reg    (dec_src2_reg),
        .rd          (dec_rd),
        .funct3      (dec_funct3),
        .funct7      (dec_funct7),
        .op          (dec_op),
        .src2_data   (dec_src2_data),
        .src2_valid  (dec_src2_valid),
        .cw_pc       (dec_cw_pc)
    );

    instr_queue #(
        .IQ_DEPTH (IQ_DEPTH)
    ) instr_queue_inst (
        .clk            (clk),
        .rst            (rst),
        .flush          (redirect),   // redirect empties the queue
        .ld_iq          (ld_iq),
        .dec_src1_reg   (dec_src1_reg),
        .dec_src2_reg   (dec_src2_reg),
        .dec_rd         (dec_rd),
        .dec_funct3     (dec_funct3),
        .dec_funct7     (dec_funct7),
        .dec_op         (dec_op),
        .dec_src2_data  (dec_src2_data),
        .dec_src2_valid (dec_src2_valid),
        .dec_cw_pc      (dec_cw_pc),
        .iq_deq         (iq_deq),
        .iq_accept      (iq_accept),
        .iq_valid       (iq_valid),
        .src1_reg       (src1_reg),
        .src2_reg       (src2_reg),
        .rd             (rd),
        .funct3         (funct3),
        .funct7         (funct7),
        .op             (op),
        .src2_data      (src2_data),
        .src2_valid     (src2_valid),
        .cw_pc          (cw_pc)
    );

endmodule

// File: tb_fetch_decode.sv
`timescale 1ns/1ps

module tb_fetch_decode;

    import issue_pkg::*;

    localparam logic [31:0] RESET_PC       = 32'h0000_0000;
    localparam int          IQ_DEPTH       = 4;
    localparam int          N_INSTR        = 200;   // pops over all tests plus slack
    localparam int          TIMEOUT_CYCLES = N_INSTR * 40 + 1000;

    logic        clk, rst, instr_mem_resp, instr_read, redirect, iq_deq, iq_valid;
    logic        funct7, src2_valid;
    logic [31:0] instr_rdata, instr_mem_address, redirect_pc, src2_data, cw_pc;
    logic [4:0]  src1_reg, src2_reg, rd;
    logic [2:0]  funct3;
    op_class     op;

    logic [31:0] prog [256];   // word index is address bits [9:2]
    logic [6:0]  legal_ops [10] = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111,
                                    7'b1100011, 7'b0000011, 7'b0100011, 7'b0010011,
                                    7'b0110011, 7'b1110011};
    bit          seen [128];
    integer      seed = 32'hd8d50c25;
    int          errors, test_errors, pass_count, fail_count, pops, req_count, wait_cycles;
    logic        pending, deq_on;
    logic [31:0] req_addr, exp_req_addr, exp_pop_pc;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    fetch_decode_top #(
        .RESET_PC (RESET_PC),
        .IQ_DEPTH (IQ_DEPTH)
    ) fetch_decode_top_inst (
        .clk (clk), .rst (rst),
        .instr_mem_resp (instr_mem_resp), .instr_rdata (instr_rdata),
        .instr_read (instr_read), .instr_mem_address (instr_mem_address),
        .redirect (redirect), .redirect_pc (redirect_pc),
        .iq_deq (iq_deq), .iq_valid (iq_valid),
        .src1_reg (src1_reg), .src2_reg (src2_reg), .rd (rd),
        .funct3 (funct3), .funct7 (funct7), .op (op),
        .src2_data (src2_data), .src2_valid (src2_valid), .cw_pc (cw_pc)
    );

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        $display("ERROR %0t %s: got %h, expected %h", $time, name, got, expected);
        errors = errors + 1;
    endtask

    task automatic report_fail(input string msg);
        $display("%0t %s", $time, msg);
        errors = errors + 1;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            pass_count = pass_count + 1;
            $display("test %s: ok", name);
        end else begin
            fail_count = fail_count + 1;
            $display("test %s: %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // expected op class and second operand from the rv32i encodings
    function automatic void ref_decode(input logic [31:0] w, output op_class exp_op,
                                       output logic [31:0] imm, output logic imm_v);
        exp_op = ARITH;
        imm    = {{20{w[31]}}, w[31:20]};
        imm_v  = 1'b1;
        case (w[6:0])
            7'b0110111: begin
                exp_op = LUI;
                imm    = {w[31:12], 12'h000};
            end
            7'b0010111: begin
                exp_op = AUIPC;
                imm    = {w[31:12], 12'h000};
            end
            7'b1101111: begin
                exp_op = JAL;
                imm    = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1100011: begin
                exp_op = BRANCH;
                imm    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            7'b0100011: begin
                exp_op = ST;
                imm    = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            7'b1100111: exp_op = JALR;
            7'b0000011: exp_op = LD;
            7'b0010011, 7'b1110011: ;   // arith with i-immediate
            default: begin
                imm   = '0;
                imm_v = 1'b0;
            end
        endcase
    endfunction

    task automatic check_entry;
        logic [31:0] w;
        logic [31:0] imm;
        logic        imm_v;
        op_class     exp_op;
        w = prog[exp_pop_pc[9:2]];
        ref_decode(w, exp_op, imm, imm_v);
        seen[w[6:0]] = 1'b1;
        assert (cw_pc == exp_pop_pc) else report_value("cw_pc", cw_pc, exp_pop_pc);
        assert (src1_reg == w[19:15]) else report_value("src1_reg", src1_reg, w[19:15]);
        assert (src2_reg == w[24:20]) else report_value("src2_reg", src2_reg, w[24:20]);
        assert (rd == w[11:7]) else report_value("rd", rd, w[11:7]);
        assert (funct3 == w[14:12]) else report_value("funct3", funct3, w[14:12]);
        assert (funct7 == w[30]) else report_value("funct7", funct7, w[30]);
        assert (op == exp_op) else report_value("op", op, exp_op);
        assert (src2_data == imm) else report_value("src2_data", src2_data, imm);
        assert (src2_valid == imm_v) else report_value("src2_valid", src2_valid, imm_v);
    endtask

    task automatic wait_pops(input int n);
        int target;
        target = pops + n;
        while (pops < target) begin
            @(posedge clk);
        end
    endtask

    task automatic do_redirect(input logic [31:0] target);
        @(negedge clk);
        redirect    = 1'b1;
        redirect_pc = target;
        @(negedge clk);
        redirect = 1'b0;
    endtask

    // memory model with 1 to 4 cycle latency and the issue side pops
    always @(negedge clk) begin
        instr_mem_resp = 1'b0;
        if (rst) begin
            pending = 1'b0;
        end else if (pending) begin
            if (wait_cycles > 1) begin
                wait_cycles = wait_cycles - 1;
            end else begin
                instr_mem_resp = 1'b1;
                instr_rdata    = prog[req_addr[9:2]];
                pending        = 1'b0;
            end
        end else if (instr_read) begin
            req_addr = instr_mem_address;
            assert (req_addr == exp_req_addr)
                else report_value("instr_mem_address", req_addr, exp_req_addr);
            assert (req_addr <= exp_pop_pc + 4 * IQ_DEPTH)
                else report_fail("fetch ran more than the queue depth ahead of the head");
            exp_req_addr = req_addr + 32'd4;
            req_count    = req_count + 1;
            pending      = 1'b1;
            wait_cycles  = 1 + $unsigned($random(seed)) % 4;
        end
        iq_deq = deq_on && ($random(seed) & 1);
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (redirect) begin
                exp_pop_pc   = redirect_pc;
                exp_req_addr = redirect_pc;
            end else if (iq_deq && iq_valid) begin
                check_entry();
                exp_pop_pc = exp_pop_pc + 32'd4;
                pops       = pops + 1;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk) $past(rst) |-> !instr_read && !iq_valid)
        else report_fail("instr_read or iq_valid active in or right after reset");

    flush_empties: assert property (@(posedge clk) disable iff (rst) redirect |=> !iq_valid)
        else report_fail("queue still valid the cycle after a redirect");

    initial begin
        logic [31:0] word;
        rst = 1'b1;
        redirect = 1'b0;
        redirect_pc = '0;
        iq_deq = 1'b0;
        instr_mem_resp = 1'b0;
        instr_rdata = '0;
        pending = 1'b0;
        deq_on = 1'b0;
        wait_cycles = 0;
        errors = 0;
        test_errors = 0;
        pass_count = 0;
        fail_count = 0;
        pops = 0;
        req_count = 0;
        exp_req_addr = RESET_PC;
        exp_pop_pc = RESET_PC;
        for (int i = 0; i < 256; i++) begin
            word    = $random(seed);
            prog[i] = {word[31:7], legal_ops[$unsigned($random(seed)) % 10]};
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        while (req_count == 0) begin
            @(posedge clk);
        end
        end_test("reset and first fetch");

        @(posedge clk);
        deq_on = 1'b1;
        wait_pops(120);
        for (int i = 0; i < 10; i++) begin
            assert (seen[legal_ops[i]]) else report_fail("an opcode was never decoded");
        end
        end_test("decode of random stream");

        // long dequeue stall fills the queue
        @(posedge clk);
        deq_on = 1'b0;
        repeat (60) @(posedge clk);
        assert (iq_valid && !instr_read) else report_fail("fetch kept running with a full queue");
        deq_on = 1'b1;
        wait_pops(20);
        end_test("full queue and resume");

        for (int i = 0; i < 6; i++) begin
            repeat (2 + $unsigned($random(seed)) % 8) @(posedge clk);
            if (i % 2 == 1) begin
                while (!(pending && wait_cycles > 1)) begin   // land on an open request
                    @(posedge clk);
                end
            end
            do_redirect($random(seed) & 32'h0000_03fc);
            wait_pops(3);
        end
        end_test("redirect");

        $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, errors);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: sources.f
rv32i_pkg.sv
issue_pkg.sv
pc_counter.sv
fetch_ctrl.sv
instr_decoder.sv
instr_queue.sv
fetch_decode_top.sv
tb_fetch_decode.sv

// File: Bender.yml
package:
  name: fetch_decode

sources:
  - rv32i_pkg.sv
  - issue_pkg.sv
  - pc_counter.sv
  - fetch_ctrl.sv
  - instr_decoder.sv
  - instr_queue.sv
  - fetch_decode_top.sv
  - target: simulation
    files:
      - tb_fetch_decode.sv
